// File: logic/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// AXI data bus width in bits
`define DATA_BITS 32

// Word address width, so the bus addresses words and not bytes
`define ADDR_BITS 24

// Transaction ID width
`define ID_BITS 4

// Default depth exponents
`define FIFO_ABITS 9
`define RAM_ABITS 10

`endif

// File: logic/axi_pkg.sv
package axi_pkg;

`include "bridge_defs.svh"

  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`ID_BITS-1:0] id_t;
  typedef logic [`DATA_BITS-1:0] data_t;
  typedef logic [`DATA_BITS/8-1:0] strb_t;

  // Beats minus one
  typedef logic [7:0] len_t;

  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  localparam burst_t BURST_INCR = 2'b01;

  // Response codes in use
  localparam resp_t OKAY = 2'b00;
  localparam resp_t SLVERR = 2'b10;

endpackage

// File: logic/stream_pkg.sv
package stream_pkg;

  typedef logic [7:0] byte_t;

  // Five command bytes, first byte ends up in the top field
  typedef struct packed {
    axi_pkg::len_t len;
    logic write;
    logic [6-$bits(axi_pkg::id_t):0] rsvd;
    axi_pkg::id_t id;
    axi_pkg::addr_t addr;
  } cmd_t;

  localparam int CMD_BYTES = 5;

  // Top two bits of the error report byte
  localparam logic [1:0] ERR_READ = 2'b10;
  localparam logic [1:0] ERR_WRITE = 2'b01;

  typedef struct packed {
    logic last;
    axi_pkg::strb_t strb;
    axi_pkg::data_t data;
  } wr_beat_t;

  typedef struct packed {
    logic last;
    axi_pkg::data_t data;
  } rd_beat_t;

  typedef enum logic [2:0] {IDLE, CMD, READ, WAIT, SEND, RECV, WRIT, FAIL} bridge_state_t;

endpackage

// File: logic/beat_fifo.sv
`timescale 1ns/10ps
`include "bridge_defs.svh"

module beat_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int ABITS = `FIFO_ABITS
) (
  input  logic     clock,
  input  logic     reset,

  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,

  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  localparam int DEPTH = 1 << ABITS;

  payload_t mem [DEPTH];
  logic [ABITS:0] wr_ptr_q;
  logic [ABITS:0] rd_ptr_q;
  logic empty;
  logic push;
  logic load;

  // Pointers carry an extra wrap bit, full when only that bit differs
  assign empty = wr_ptr_q == rd_ptr_q;
  assign ready_o = (wr_ptr_q ^ rd_ptr_q) != {1'b1, {ABITS{1'b0}}};
  assign push = valid_i && ready_o;

  // Refill the output stage when it is empty or being taken
  assign load = !empty && (!valid_o || ready_i);

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q[ABITS-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      data_o <= mem[rd_ptr_q[ABITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + (ABITS+1)'(1);
      end
      if (load) begin
        rd_ptr_q <= rd_ptr_q + (ABITS+1)'(1);
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end
    end
  end

endmodule

// File: logic/axis_mem_bridge.sv
`timescale 1ns/10ps
`include "bridge_defs.svh"

module axis_mem_bridge (
  input  logic              clock,
  input  logic              reset,

  input  logic              s_valid_i,
  output logic              s_ready_o,
  input  logic              s_last_i,
  input  stream_pkg::byte_t s_data_i,

  output logic              m_valid_o,
  input  logic              m_ready_i,
  output logic              m_last_o,
  output stream_pkg::byte_t m_data_o,

  output logic              awvalid_o,
  input  logic              awready_i,
  output axi_pkg::burst_t   awburst_o,
  output axi_pkg::len_t     awlen_o,
  output axi_pkg::id_t      awid_o,
  output axi_pkg::addr_t    awaddr_o,

  output logic              wvalid_o,
  input  logic              wready_i,
  output logic              wlast_o,
  output axi_pkg::strb_t    wstrb_o,
  output axi_pkg::data_t    wdata_o,

  input  logic              bvalid_i,
  output logic              bready_o,
  input  axi_pkg::id_t      bid_i,
  input  axi_pkg::resp_t    bresp_i,

  output logic              arvalid_o,
  input  logic              arready_i,
  output axi_pkg::burst_t   arburst_o,
  output axi_pkg::len_t     arlen_o,
  output axi_pkg::id_t      arid_o,
  output axi_pkg::addr_t    araddr_o,

  input  logic              rvalid_i,
  output logic              rready_o,
  input  logic              rlast_i,
  input  axi_pkg::id_t      rid_i,
  input  axi_pkg::resp_t    rresp_i,
  input  axi_pkg::data_t    rdata_i
);

  import axi_pkg::*;
  import stream_pkg::*;

  bridge_state_t state_q;
  cmd_t cmd_q;
  cmd_t cmd_next;
  logic [2:0] cnt_q;
  logic [`DATA_BITS-9:0] pack_q;
  logic flush_q;
  logic s_fire;
  logic m_fire;
  logic m_free;
  logic r_fire;
  logic wr_push;
  logic wr_ready;
  logic rd_valid;
  logic rd_pop;
  wr_beat_t wr_beat;
  rd_beat_t rd_beat;
  byte_t rd_byte;

  assign s_fire = s_valid_i && s_ready_o;
  assign m_fire = m_valid_o && m_ready_i;
  assign m_free = !m_valid_o || m_ready_i;
  assign r_fire = rvalid_i && rready_o;
  assign cmd_next = cmd_t'({cmd_q[$bits(cmd_t)-9:0], s_data_i});

  always_comb begin
    case (state_q)
      IDLE, CMD: s_ready_o = 1'b1;
      RECV: s_ready_o = wr_ready;
      default: s_ready_o = 1'b0;
    endcase
  end

  // Address channels share the latched command
  assign awburst_o = BURST_INCR;
  assign awlen_o = cmd_q.len;
  assign awid_o = cmd_q.id;
  assign awaddr_o = cmd_q.addr;
  assign arburst_o = BURST_INCR;
  assign arlen_o = cmd_q.len;
  assign arid_o = cmd_q.id;
  assign araddr_o = cmd_q.addr;
  assign bready_o = state_q == WRIT;

  // Fourth byte of a word completes it straight from the stream
  assign wr_push = state_q == RECV && s_valid_i && wr_ready && cnt_q[1:0] == 2'd3;

  // Serializer takes a word after its top byte, FAIL drains a bad burst
  assign rd_pop = (state_q == SEND && m_free && cnt_q[1:0] == 2'd3)
                  || (state_q == FAIL && flush_q);
  assign rd_byte = rd_beat.data[{cnt_q[1:0], 3'b000} +: 8];

  always_ff @(posedge clock) begin
    if (s_fire && (state_q == IDLE || state_q == CMD)) begin
      cmd_q <= cmd_next;
    end
    if (s_fire && state_q == RECV) begin
      pack_q <= {s_data_i, pack_q[`DATA_BITS-9:8]};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      cnt_q <= '0;
      flush_q <= 1'b0;
      m_valid_o <= 1'b0;
      m_last_o <= 1'b0;
      awvalid_o <= 1'b0;
      arvalid_o <= 1'b0;
    end else begin
      // AW may be taken while the data bytes are still arriving
      if (awvalid_o && awready_i) begin
        awvalid_o <= 1'b0;
      end

      case (state_q)
        IDLE: begin
          if (s_fire) begin
            cnt_q <= 3'd1;
            state_q <= CMD;
          end
        end

        CMD: begin
          if (s_fire) begin
            cnt_q <= cnt_q + 3'd1;
            if (cnt_q == 3'(CMD_BYTES - 1)) begin
              cnt_q <= '0;
              if (cmd_next.write) begin
                awvalid_o <= 1'b1;
                state_q <= RECV;
              end else begin
                arvalid_o <= 1'b1;
                state_q <= READ;
              end
            end
          end
        end

        READ: begin
          if (arready_i) begin
            arvalid_o <= 1'b0;
            state_q <= WAIT;
          end
        end

        // Whole burst lands in the read FIFO before any byte goes out
        WAIT: begin
          if (r_fire && rlast_i) begin
            if (rid_i != cmd_q.id || rresp_i != OKAY) begin
              m_valid_o <= 1'b1;
              m_last_o <= 1'b1;
              m_data_o <= {ERR_READ, rresp_i, rid_i};
              flush_q <= 1'b1;
              state_q <= FAIL;
            end else begin
              cnt_q <= '0;
              state_q <= SEND;
            end
          end
        end

        SEND: begin
          if (m_free) begin
            m_valid_o <= rd_valid;
            m_last_o <= rd_valid && cnt_q[1:0] == 2'd3 && rd_beat.last;
            m_data_o <= rd_byte;
            if (rd_valid) begin
              cnt_q <= {1'b0, cnt_q[1:0] + 2'd1};
            end
          end
          if (m_fire && m_last_o) begin
            state_q <= IDLE;
          end
        end

        RECV: begin
          if (s_fire) begin
            cnt_q <= {1'b0, cnt_q[1:0] + 2'd1};
            if (s_last_i) begin
              state_q <= WRIT;
            end
          end
        end

        WRIT: begin
          if (bvalid_i) begin
            if (bid_i != cmd_q.id || bresp_i != OKAY) begin
              m_valid_o <= 1'b1;
              m_last_o <= 1'b1;
              m_data_o <= {ERR_WRITE, bresp_i, bid_i};
              state_q <= FAIL;
            end else begin
              state_q <= IDLE;
            end
          end
        end

        // Error byte out and, after a read, the stale burst discarded
        FAIL: begin
          if (m_ready_i) begin
            m_valid_o <= 1'b0;
            m_last_o <= 1'b0;
          end
          if (flush_q && rd_valid && rd_beat.last) begin
            flush_q <= 1'b0;
          end
          if (m_free && (!flush_q || (rd_valid && rd_beat.last))) begin
            state_q <= IDLE;
          end
        end

        default: state_q <= IDLE;
      endcase
    end
  end

  beat_fifo #(
    .payload_t(wr_beat_t),
    .ABITS    (`FIFO_ABITS)
  ) wr_fifo (
    .clock  (clock),
    .reset  (reset),
    .valid_i(wr_push),
    .ready_o(wr_ready),
    .data_i ('{last: s_last_i, strb: '1, data: {s_data_i, pack_q}}),
    .valid_o(wvalid_o),
    .ready_i(wready_i),
    .data_o (wr_beat)
  );

  assign wlast_o = wr_beat.last;
  assign wstrb_o = wr_beat.strb;
  assign wdata_o = wr_beat.data;

  beat_fifo #(
    .payload_t(rd_beat_t),
    .ABITS    (`FIFO_ABITS)
  ) rd_fifo (
    .clock  (clock),
    .reset  (reset),
    .valid_i(rvalid_i),
    .ready_o(rready_o),
    .data_i ('{last: rlast_i, data: rdata_i}),
    .valid_o(rd_valid),
    .ready_i(rd_pop),
    .data_o (rd_beat)
  );

endmodule

// File: logic/axi_ram.sv
`timescale 1ns/10ps
`include "bridge_defs.svh"

module axi_ram #(
  parameter int ABITS = `RAM_ABITS
) (
  input  logic            clock,
  input  logic            reset,

  input  logic            awvalid_i,
  output logic            awready_o,
  input  axi_pkg::burst_t awburst_i,
  input  axi_pkg::len_t   awlen_i,
  input  axi_pkg::id_t    awid_i,
  input  axi_pkg::addr_t  awaddr_i,

  input  logic            wvalid_i,
  output logic            wready_o,
  input  logic            wlast_i,
  input  axi_pkg::strb_t  wstrb_i,
  input  axi_pkg::data_t  wdata_i,

  output logic            bvalid_o,
  input  logic            bready_i,
  output axi_pkg::id_t    bid_o,
  output axi_pkg::resp_t  bresp_o,

  input  logic            arvalid_i,
  output logic            arready_o,
  input  axi_pkg::burst_t arburst_i,
  input  axi_pkg::len_t   arlen_i,
  input  axi_pkg::id_t    arid_i,
  input  axi_pkg::addr_t  araddr_i,

  output logic            rvalid_o,
  input  logic            rready_i,
  output logic            rlast_o,
  output axi_pkg::id_t    rid_o,
  output axi_pkg::resp_t  rresp_o,
  output axi_pkg::data_t  rdata_o
);

  import axi_pkg::*;

  typedef enum logic [1:0] {RAM_IDLE, RAM_WRITE, RAM_RESP, RAM_READ} ram_state_t;

  ram_state_t state_q;
  data_t mem [2**ABITS];
  addr_t addr_q;
  addr_t addr_next;
  addr_t rd_addr;
  len_t len_q;
  len_t cnt_q;
  id_t id_q;
  burst_t burst_q;
  logic err_q;
  logic w_err;
  logic aw_fire;
  logic ar_fire;
  logic w_fire;
  logic r_fire;
  logic r_load;

  function automatic logic in_range(addr_t addr);
    return (addr >> ABITS) == '0;
  endfunction

  // Writes win when both address channels are offered together
  assign awready_o = state_q == RAM_IDLE;
  assign arready_o = state_q == RAM_IDLE && !awvalid_i;
  assign wready_o = state_q == RAM_WRITE;

  assign aw_fire = awvalid_i && awready_o;
  assign ar_fire = arvalid_i && arready_o;
  assign w_fire = wvalid_i && wready_o;
  assign r_fire = rvalid_o && rready_i;

  // Non-INCR bursts stay on one word
  assign addr_next = burst_q == BURST_INCR ? addr_q + addr_t'(1) : addr_q;
  assign rd_addr = ar_fire ? araddr_i : addr_next;
  assign r_load = ar_fire || (r_fire && !rlast_o);

  // A wlast that disagrees with awlen also counts as an error
  assign w_err = !in_range(addr_q) || (wlast_i != (cnt_q == len_q));

  always_ff @(posedge clock) begin
    if (aw_fire) begin
      addr_q <= awaddr_i;
      len_q <= awlen_i;
      id_q <= awid_i;
      burst_q <= awburst_i;
      cnt_q <= '0;
    end else if (ar_fire) begin
      addr_q <= araddr_i;
      len_q <= arlen_i;
      burst_q <= arburst_i;
      cnt_q <= '0;
    end else if (w_fire || r_fire) begin
      addr_q <= addr_next;
      cnt_q <= cnt_q + len_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (w_fire && in_range(addr_q)) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (wstrb_i[i]) begin
          mem[addr_q[ABITS-1:0]][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Out-of-range beats read as zero with SLVERR
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rid_o <= arid_i;
    end
    if (r_load) begin
      rdata_o <= in_range(rd_addr) ? mem[rd_addr[ABITS-1:0]] : '0;
      rresp_o <= in_range(rd_addr) ? OKAY : SLVERR;
      rlast_o <= ar_fire ? arlen_i == '0 : cnt_q + len_t'(1) == len_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= RAM_IDLE;
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      err_q <= 1'b0;
    end else begin
      case (state_q)
        RAM_IDLE: begin
          if (aw_fire) begin
            err_q <= 1'b0;
            state_q <= RAM_WRITE;
          end else if (ar_fire) begin
            rvalid_o <= 1'b1;
            state_q <= RAM_READ;
          end
        end
        RAM_WRITE: begin
          if (w_fire) begin
            err_q <= err_q || w_err;
            if (wlast_i) begin
              bvalid_o <= 1'b1;
              bid_o <= id_q;
              bresp_o <= (err_q || w_err) ? SLVERR : OKAY;
              state_q <= RAM_RESP;
            end
          end
        end
        RAM_RESP: begin
          if (bready_i) begin
            bvalid_o <= 1'b0;
            state_q <= RAM_IDLE;
          end
        end
        default: begin
          if (r_fire && rlast_o) begin
            rvalid_o <= 1'b0;
            state_q <= RAM_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: logic/usb_mem_top.sv
`timescale 1ns/10ps

module usb_mem_top (
  input  logic              clock,
  input  logic              reset,

  input  logic              s_valid_i,
  output logic              s_ready_o,
  input  logic              s_last_i,
  input  stream_pkg::byte_t s_data_i,

  output logic              m_valid_o,
  input  logic              m_ready_i,
  output logic              m_last_o,
  output stream_pkg::byte_t m_data_o
);

  import axi_pkg::*;

  // AXI4 link between the bridge and the RAM
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  burst_t awburst, arburst;
  len_t awlen, arlen;
  id_t awid, bid, arid, rid;
  addr_t awaddr, araddr;
  strb_t wstrb;
  data_t wdata, rdata;
  resp_t bresp, rresp;

  axis_mem_bridge axis_mem_bridge_i (
    .clock, .reset,
    .s_valid_i, .s_ready_o, .s_last_i, .s_data_i,
    .m_valid_o, .m_ready_i, .m_last_o, .m_data_o,
    .awvalid_o(awvalid), .awready_i(awready), .awburst_o(awburst),
    .awlen_o(awlen), .awid_o(awid), .awaddr_o(awaddr),
    .wvalid_o(wvalid), .wready_i(wready), .wlast_o(wlast),
    .wstrb_o(wstrb), .wdata_o(wdata),
    .bvalid_i(bvalid), .bready_o(bready), .bid_i(bid), .bresp_i(bresp),
    .arvalid_o(arvalid), .arready_i(arready), .arburst_o(arburst),
    .arlen_o(arlen), .arid_o(arid), .araddr_o(araddr),
    .rvalid_i(rvalid), .rready_o(rready), .rlast_i(rlast),
    .rid_i(rid), .rresp_i(rresp), .rdata_i(rdata)
  );

  axi_ram axi_ram_i (
    .clock, .reset,
    .awvalid_i(awvalid), .awready_o(awready), .awburst_i(awburst),
    .awlen_i(awlen), .awid_i(awid), .awaddr_i(awaddr),
    .wvalid_i(wvalid), .wready_o(wready), .wlast_i(wlast),
    .wstrb_i(wstrb), .wdata_i(wdata),
    .bvalid_o(bvalid), .bready_i(bready), .bid_o(bid), .bresp_o(bresp),
    .arvalid_i(arvalid), .arready_o(arready), .arburst_i(arburst),
    .arlen_i(arlen), .arid_i(arid), .araddr_i(araddr),
    .rvalid_o(rvalid), .rready_i(rready), .rlast_o(rlast),
    .rid_o(rid), .rresp_o(rresp), .rdata_o(rdata)
  );

endmodule

// File: test/usb_mem_cases.svh
`ifndef USB_MEM_CASES_SVH
`define USB_MEM_CASES_SVH

// How the sink drives m_ready_i while a case runs
typedef enum logic [1:0] {SINK_ON, SINK_RAND, SINK_STALL} sink_mode_t;

// One command per row. Write data follows from the word address,
// read data from what earlier rows wrote. err_byte is the single
// response byte when fails is set
typedef struct packed {
  logic write;
  axi_pkg::id_t id;
  axi_pkg::addr_t addr;
  axi_pkg::len_t len;
  sink_mode_t sink;
  logic fails;
  stream_pkg::byte_t err_byte;
} case_t;

localparam int NUM_CASES = 10;

// Error byte is {code 10 read or 01 write, SLVERR 10, ID}
localparam case_t CASES [NUM_CASES] = '{
  // Single beat, written then read back
  '{1'b1, 4'h3, 24'h000010, 8'd0, SINK_ON, 1'b0, 8'h00},
  '{1'b0, 4'h3, 24'h000010, 8'd0, SINK_ON, 1'b0, 8'h00},
  // Eight beats with a random sink
  '{1'b1, 4'h7, 24'h000040, 8'd7, SINK_RAND, 1'b0, 8'h00},
  '{1'b0, 4'h7, 24'h000040, 8'd7, SINK_RAND, 1'b0, 8'h00},
  // Reads past the RAM
  '{1'b0, 4'h5, 24'h000400, 8'd0, SINK_ON, 1'b1, 8'b10_10_0101},
  '{1'b0, 4'h9, 24'h123456, 8'd3, SINK_RAND, 1'b1, 8'b10_10_1001},
  // Write past the RAM, then a good read
  '{1'b1, 4'h6, 24'h000400, 8'd0, SINK_ON, 1'b1, 8'b01_10_0110},
  '{1'b0, 4'h1, 24'h000047, 8'd0, SINK_ON, 1'b0, 8'h00},
  // Full 256 beat burst, read back against a mostly stalled sink
  '{1'b1, 4'h4, 24'h000100, 8'd255, SINK_ON, 1'b0, 8'h00},
  '{1'b0, 4'h4, 24'h000100, 8'd255, SINK_STALL, 1'b0, 8'h00}
};

`endif

// File: test/usb_mem_tb.sv
`timescale 1ns/10ps

module usb_mem_tb;

  import axi_pkg::*;
  import stream_pkg::*;

`include "usb_mem_cases.svh"

  logic clock;
  logic reset;
  logic s_valid_i;
  logic s_ready_o;
  logic s_last_i;
  byte_t s_data_i;
  logic m_valid_o;
  logic m_ready_i;
  logic m_last_o;
  byte_t m_data_o;

  integer seed = 32'hbc5c_1c7a;
  sink_mode_t sink_mode = SINK_ON;
  sink_mode_t mode_now;
  int stretch = 0;
  int rx_count = 0;

  // Expected response bytes and their last flags in arrival order
  byte_t exp_data_q [$];
  logic exp_last_q [$];

  // Words the RAM should hold
  data_t model_mem [addr_t];

  usb_mem_top usb_mem_top_i (
    .clock, .reset,
    .s_valid_i, .s_ready_o, .s_last_i, .s_data_i,
    .m_valid_o, .m_ready_i, .m_last_o, .m_data_o
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_byte(byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("[FAIL] m_data_o: got 0x%02h, expected 0x%02h at response byte %0d",
               got, exp, rx_count);
      abort_run();
    end
  endtask

  task automatic check_last(logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] m_last_o: got 0x%0h, expected 0x%0h at response byte %0d",
               got, exp, rx_count);
      abort_run();
    end
  endtask

  task automatic check_quiet(byte_t got, int pending);
    if (pending == 0) begin
      $display("Response byte 0x%02h arrived while no response was due", got);
      abort_run();
    end
  endtask

  // Address dependent word pattern salted by the case index
  function automatic data_t fill_word(addr_t a, int salt);
    return (data_t'(a) * 32'h9e37_79b1) ^ {4{8'(salt)}};
  endfunction

  // Packet bytes plus response bytes of one row
  function automatic int table_bytes(case_t c);
    int beat_bytes;
    beat_bytes = 4 * (int'(c.len) + 1);
    if (c.fails) begin
      return CMD_BYTES + 1 + (c.write ? beat_bytes : 0);
    end
    return CMD_BYTES + beat_bytes;
  endfunction

  task automatic expect_byte(byte_t b, logic last);
    exp_data_q.push_back(b);
    exp_last_q.push_back(last);
  endtask

  task automatic send_packet(input byte_t pkt [$]);
    for (int n = 0; n < pkt.size(); n++) begin
      s_valid_i = 1'b1;
      s_data_i = pkt[n];
      s_last_i = n == pkt.size() - 1;
      @(posedge clock);
      while (!s_ready_o) @(posedge clock);
      #1;
    end
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
  endtask

  // Done once all expected bytes are in and the bridge takes commands again
  task automatic wait_idle();
    do begin
      @(posedge clock);
      #1;
    end while (exp_data_q.size() != 0 || !s_ready_o);
  endtask

  task automatic run_case(int idx);
    case_t c;
    byte_t pkt [$];
    data_t word;
    addr_t a;
    c = CASES[idx];
    sink_mode = c.sink;
    pkt.push_back(c.len);
    pkt.push_back({c.write, 3'b000, c.id});
    pkt.push_back(c.addr[23:16]);
    pkt.push_back(c.addr[15:8]);
    pkt.push_back(c.addr[7:0]);
    if (c.fails) begin
      expect_byte(c.err_byte, 1'b1);
    end
    for (int beat = 0; beat <= int'(c.len); beat++) begin
      a = c.addr + addr_t'(beat);
      if (c.write) begin
        word = fill_word(a, idx);
        for (int k = 0; k < 4; k++) begin
          pkt.push_back(word[8*k +: 8]);
        end
        if (!c.fails) begin
          model_mem[a] = word;
        end
      end else if (!c.fails) begin
        if (!model_mem.exists(a)) begin
          $display("Case %0d reads word 0x%06h that no earlier case wrote", idx, a);
          abort_run();
        end
        word = model_mem[a];
        for (int k = 0; k < 4; k++) begin
          expect_byte(word[8*k +: 8], beat == int'(c.len) && k == 3);
        end
      end
    end
    send_packet(pkt);
    wait_idle();
  endtask

  // Sink ready follows the mode seen at each clock edge
  initial begin
    m_ready_i = 1'b1;
    forever begin
      @(posedge clock);
      mode_now = sink_mode;
      #1;
      case (mode_now)
        SINK_RAND: m_ready_i = 1'($random(seed));
        SINK_STALL: begin
          if (stretch == 0) begin
            m_ready_i = !m_ready_i;
            stretch = m_ready_i ? 1 + ($random(seed) & 7) : 20 + ($random(seed) & 63);
          end else begin
            stretch = stretch - 1;
          end
        end
        default: m_ready_i = 1'b1;
      endcase
    end
  end

  // Response monitor
  always @(posedge clock) begin
    if (!reset && m_valid_o && m_ready_i) begin
      check_quiet(m_data_o, exp_data_q.size());
      check_byte(m_data_o, exp_data_q.pop_front());
      check_last(m_last_o, exp_last_q.pop_front());
      rx_count = rx_count + 1;
    end
  end

  initial begin
    int limit;
    limit = 1000;
    for (int i = 0; i < NUM_CASES; i++) begin
      limit = limit + 200 * table_bytes(CASES[i]);
    end
    repeat (limit) @(posedge clock);
    $display("Timeout after %0d cycles with %0d response bytes still due",
             limit, exp_data_q.size());
    abort_run();
  end

  initial begin
    reset = 1'b1;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
    s_data_i = '0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
+incdir+test
logic/axi_pkg.sv
logic/stream_pkg.sv
logic/beat_fifo.sv
logic/axis_mem_bridge.sv
logic/axi_ram.sv
logic/usb_mem_top.sv
test/usb_mem_tb.sv

// File: Makefile
OBJ_DIR := obj_dir

.PHONY: sim clean

# Build and run, a $fatal in the testbench gives a failing exit status
sim:
	verilator --binary --timing -j 0 --top-module usb_mem_tb \
		--Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/Vusb_mem_tb

clean:
	rm -rf $(OBJ_DIR)
